/* rtl/idu_pkg.sv */
package idu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [31:0]           instr_t;
    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [6:0]            opcode_t;

    // major opcodes of the base integer set
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;

    localparam logic [6:0] FUNCT7_NORM = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

    // named after the arithmetic group, reused for branch, load and store
    localparam logic [2:0] FUNCT3_ADD  = 3'b000;
    localparam logic [2:0] FUNCT3_SLL  = 3'b001;
    localparam logic [2:0] FUNCT3_SLT  = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU = 3'b011;
    localparam logic [2:0] FUNCT3_XOR  = 3'b100;
    localparam logic [2:0] FUNCT3_SR   = 3'b101;
    localparam logic [2:0] FUNCT3_OR   = 3'b110;
    localparam logic [2:0] FUNCT3_AND  = 3'b111;

    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_XOR, OP_OR, OP_AND,
        OP_SLL, OP_SRL, OP_SRA,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR
    } alu_op_e;

    typedef enum logic [2:0] {
        FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J
    } imm_fmt_e;

    // result from a later stage, ld marks a load still in flight
    typedef struct packed {
        logic      vld;
        logic      ld;
        reg_addr_t addr;
        word_t     data;
    } wb_fwd_t;

    typedef struct packed {
        logic      vld;
        reg_addr_t addr;
        word_t     data;
    } rf_wb_t;

    typedef struct packed {
        alu_op_e   op;
        word_t     src1;
        word_t     src2;
        word_t     br_st_imm;
        word_t     pc;
        reg_addr_t wb_addr;
        logic      wb_vld;
    } alu_req_t;

endpackage

/* rtl/idu_op_decoder.sv */
module idu_op_decoder (
    input  idu_pkg::instr_t   instr_i,
    output idu_pkg::alu_op_e  op_o,
    output idu_pkg::imm_fmt_e fmt_o,
    output logic              use_rs1_o,
    output logic              use_rs2_o,
    output logic              src2_imm_o,
    output logic              wb_vld_o
);

    idu_pkg::opcode_t opcode;
    logic [2:0]       funct3;
    logic             f7_norm;
    logic             f7_alt;
    logic             known;
    idu_pkg::alu_op_e arith_op;

    assign opcode  = instr_i[6:0];
    assign funct3  = instr_i[14:12];
    assign f7_norm = (instr_i[31:25] == idu_pkg::FUNCT7_NORM);
    assign f7_alt  = (instr_i[31:25] == idu_pkg::FUNCT7_ALT);

    // common to OP and OP_IMM
    always_comb begin
        case (funct3)
            idu_pkg::FUNCT3_ADD:  arith_op = idu_pkg::OP_ADD;
            idu_pkg::FUNCT3_SLL:  arith_op = idu_pkg::OP_SLL;
            idu_pkg::FUNCT3_SLT:  arith_op = idu_pkg::OP_SLT;
            idu_pkg::FUNCT3_SLTU: arith_op = idu_pkg::OP_SLTU;
            idu_pkg::FUNCT3_XOR:  arith_op = idu_pkg::OP_XOR;
            idu_pkg::FUNCT3_SR:   arith_op = f7_alt ? idu_pkg::OP_SRA : idu_pkg::OP_SRL;
            idu_pkg::FUNCT3_OR:   arith_op = idu_pkg::OP_OR;
            default:              arith_op = idu_pkg::OP_AND;
        endcase
    end

    always_comb begin
        op_o  = idu_pkg::OP_NOP;
        fmt_o = idu_pkg::FMT_R;
        known = 1'b1;
        case (opcode)
            idu_pkg::OPC_OP: begin
                if (f7_norm) begin
                    op_o = arith_op;
                end else if (f7_alt && funct3 == idu_pkg::FUNCT3_ADD) begin
                    op_o = idu_pkg::OP_SUB;
                end else if (f7_alt && funct3 == idu_pkg::FUNCT3_SR) begin
                    op_o = idu_pkg::OP_SRA;
                end
            end
            idu_pkg::OPC_OP_IMM: begin
                fmt_o = idu_pkg::FMT_I;
                // shift amounts leave funct7 in the upper immediate bits
                if (funct3 == idu_pkg::FUNCT3_SLL) begin
                    op_o = f7_norm ? idu_pkg::OP_SLL : idu_pkg::OP_NOP;
                end else if (funct3 == idu_pkg::FUNCT3_SR) begin
                    op_o = (f7_norm || f7_alt) ? arith_op : idu_pkg::OP_NOP;
                end else begin
                    op_o = arith_op;
                end
            end
            idu_pkg::OPC_LOAD: begin
                fmt_o = idu_pkg::FMT_I;
                case (funct3)
                    idu_pkg::FUNCT3_ADD: op_o = idu_pkg::OP_LB;
                    idu_pkg::FUNCT3_SLL: op_o = idu_pkg::OP_LH;
                    idu_pkg::FUNCT3_SLT: op_o = idu_pkg::OP_LW;
                    idu_pkg::FUNCT3_XOR: op_o = idu_pkg::OP_LBU;
                    idu_pkg::FUNCT3_SR:  op_o = idu_pkg::OP_LHU;
                    default:             op_o = idu_pkg::OP_NOP;
                endcase
            end
            idu_pkg::OPC_STORE: begin
                fmt_o = idu_pkg::FMT_S;
                case (funct3)
                    idu_pkg::FUNCT3_ADD: op_o = idu_pkg::OP_SB;
                    idu_pkg::FUNCT3_SLL: op_o = idu_pkg::OP_SH;
                    idu_pkg::FUNCT3_SLT: op_o = idu_pkg::OP_SW;
                    default:             op_o = idu_pkg::OP_NOP;
                endcase
            end
            idu_pkg::OPC_BRANCH: begin
                fmt_o = idu_pkg::FMT_B;
                case (funct3)
                    idu_pkg::FUNCT3_ADD: op_o = idu_pkg::OP_BEQ;
                    idu_pkg::FUNCT3_SLL: op_o = idu_pkg::OP_BNE;
                    idu_pkg::FUNCT3_XOR: op_o = idu_pkg::OP_BLT;
                    idu_pkg::FUNCT3_SR:  op_o = idu_pkg::OP_BGE;
                    idu_pkg::FUNCT3_OR:  op_o = idu_pkg::OP_BLTU;
                    idu_pkg::FUNCT3_AND: op_o = idu_pkg::OP_BGEU;
                    default:             op_o = idu_pkg::OP_NOP;
                endcase
            end
            idu_pkg::OPC_LUI: begin
                fmt_o = idu_pkg::FMT_U;
                op_o  = idu_pkg::OP_LUI;
            end
            idu_pkg::OPC_AUIPC: begin
                fmt_o = idu_pkg::FMT_U;
                op_o  = idu_pkg::OP_AUIPC;
            end
            idu_pkg::OPC_JAL: begin
                fmt_o = idu_pkg::FMT_J;
                op_o  = idu_pkg::OP_JAL;
            end
            idu_pkg::OPC_JALR: begin
                fmt_o = idu_pkg::FMT_I;
                op_o  = idu_pkg::OP_JALR;
            end
            default: known = 1'b0;
        endcase
    end

    assign use_rs1_o  = (fmt_o != idu_pkg::FMT_U) && (fmt_o != idu_pkg::FMT_J);
    assign use_rs2_o  = (fmt_o == idu_pkg::FMT_R) || (fmt_o == idu_pkg::FMT_S) ||
                        (fmt_o == idu_pkg::FMT_B);
    assign src2_imm_o = (fmt_o == idu_pkg::FMT_I) || (fmt_o == idu_pkg::FMT_U) ||
                        (fmt_o == idu_pkg::FMT_J);
    // unknown opcodes never write back
    assign wb_vld_o   = known && (fmt_o != idu_pkg::FMT_S) && (fmt_o != idu_pkg::FMT_B);

endmodule

/* rtl/idu_imm_gen.sv */
module idu_imm_gen (
    input  idu_pkg::instr_t   instr_i,
    input  idu_pkg::imm_fmt_e fmt_i,
    output idu_pkg::word_t    imm_o,
    output idu_pkg::word_t    br_st_imm_o
);

    idu_pkg::word_t i_imm;
    idu_pkg::word_t s_imm;
    idu_pkg::word_t b_imm;
    idu_pkg::word_t u_imm;
    idu_pkg::word_t j_imm;

    assign i_imm = {{(idu_pkg::XLEN-12){instr_i[31]}}, instr_i[31:20]};
    assign s_imm = {{(idu_pkg::XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    // b and j offsets count halfwords so bit 0 is zero
    assign b_imm = {{(idu_pkg::XLEN-12){instr_i[31]}}, instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign j_imm = {{(idu_pkg::XLEN-20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};
    assign u_imm = {instr_i[31:12], {(idu_pkg::XLEN-20){1'b0}}};

    always_comb begin
        case (fmt_i)
            idu_pkg::FMT_I: imm_o = i_imm;
            idu_pkg::FMT_S: imm_o = s_imm;
            idu_pkg::FMT_B: imm_o = b_imm;
            idu_pkg::FMT_U: imm_o = u_imm;
            idu_pkg::FMT_J: imm_o = j_imm;
            default:        imm_o = '0;
        endcase
    end

    // target offset for branches or address offset for stores
    always_comb begin
        case (fmt_i)
            idu_pkg::FMT_B: br_st_imm_o = b_imm;
            idu_pkg::FMT_S: br_st_imm_o = s_imm;
            default:        br_st_imm_o = '0;
        endcase
    end

endmodule

/* rtl/idu_operand_bypass.sv */
module idu_operand_bypass (
    input  idu_pkg::instr_t    instr_i,
    input  logic               use_rs1_i,
    input  logic               use_rs2_i,
    input  logic               src2_imm_i,
    input  idu_pkg::word_t     imm_i,
    input  idu_pkg::word_t     rf_rs1_data_i,
    input  idu_pkg::word_t     rf_rs2_data_i,
    input  idu_pkg::wb_fwd_t   alu_wb_i,
    input  idu_pkg::wb_fwd_t   lsu_wb_i,
    input  idu_pkg::rf_wb_t    rf_wb_i,
    output idu_pkg::reg_addr_t rf_rs1_addr_o,
    output idu_pkg::reg_addr_t rf_rs2_addr_o,
    output idu_pkg::word_t     src1_o,
    output idu_pkg::word_t     src2_o,
    output logic               ld_stall_o
);

    idu_pkg::reg_addr_t rs1;
    idu_pkg::reg_addr_t rs2;
    idu_pkg::word_t     fwd2;

    // priority alu, lsu, rf write port, then file data
    function automatic idu_pkg::word_t pick(
        input idu_pkg::reg_addr_t rs,
        input logic               used,
        input idu_pkg::word_t     file_data,
        input idu_pkg::wb_fwd_t   alu,
        input idu_pkg::wb_fwd_t   lsu,
        input idu_pkg::rf_wb_t    rf
    );
        logic live;
        live = used && (rs != '0);
        if (live && alu.vld && !alu.ld && alu.addr == rs) begin
            return alu.data;
        end else if (live && lsu.vld && !lsu.ld && lsu.addr == rs) begin
            return lsu.data;
        end else if (live && rf.vld && rf.addr == rs) begin
            return rf.data;
        end
        return file_data;
    endfunction

    // source waits on a load that has no data yet
    function automatic logic load_hit(
        input idu_pkg::reg_addr_t rs,
        input logic               used,
        input idu_pkg::wb_fwd_t   alu,
        input idu_pkg::wb_fwd_t   lsu
    );
        logic live;
        live = used && (rs != '0);
        return live && ((alu.vld && alu.ld && alu.addr == rs) ||
                        (lsu.vld && lsu.ld && lsu.addr == rs));
    endfunction

    assign rs1 = instr_i[19:15];
    assign rs2 = instr_i[24:20];

    assign rf_rs1_addr_o = rs1;
    assign rf_rs2_addr_o = rs2;

    always_comb begin
        src1_o = pick(rs1, use_rs1_i, rf_rs1_data_i, alu_wb_i, lsu_wb_i, rf_wb_i);
        // x0 reads straight from the file, never from a later stage
        if (rs1 == '0) begin
            assert (src1_o == rf_rs1_data_i)
                else $error("x0 operand taken from forwarding path");
        end
    end

    assign fwd2   = pick(rs2, use_rs2_i, rf_rs2_data_i, alu_wb_i, lsu_wb_i, rf_wb_i);
    assign src2_o = src2_imm_i ? imm_i : fwd2;

    assign ld_stall_o = load_hit(rs1, use_rs1_i, alu_wb_i, lsu_wb_i) ||
                        load_hit(rs2, use_rs2_i, alu_wb_i, lsu_wb_i);

endmodule

/* rtl/idu_stage_reg.sv */
module idu_stage_reg (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              ifu_vld_i,
    input  logic              flush_i,
    input  logic              ld_stall_i,
    input  logic              alu_rdy_i,
    input  idu_pkg::alu_req_t req_i,
    output logic              idu_rdy_o,
    output logic              alu_vld_o,
    output idu_pkg::alu_req_t alu_req_o
);

    logic accept;
    logic held;

    // slot is busy while a request waits on the alu
    assign held      = alu_vld_o && !alu_rdy_i;
    assign idu_rdy_o = !held && !ld_stall_i;
    assign accept    = ifu_vld_i && idu_rdy_o && !flush_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            alu_vld_o <= 1'b0;
        end else begin
            alu_vld_o <= accept || held;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            alu_req_o <= req_i;
        end
    end

    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        held |=> alu_vld_o && $stable(alu_req_o)
    ) else $error("request changed while stalled by the alu");

    // a flush with a free slot leaves the slot empty
    a_flush_no_accept: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        flush_i && !held |=> !alu_vld_o
    ) else $error("request accepted during flush");

endmodule

/* rtl/idu.sv */
module idu (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               flush_i,
    input  logic               ifu_vld_i,
    input  idu_pkg::instr_t    ifu_instr_i,
    input  idu_pkg::word_t     ifu_pc_i,
    output logic               idu_rdy_o,
    output idu_pkg::reg_addr_t rf_rs1_addr_o,
    output idu_pkg::reg_addr_t rf_rs2_addr_o,
    input  idu_pkg::word_t     rf_rs1_data_i,
    input  idu_pkg::word_t     rf_rs2_data_i,
    input  idu_pkg::wb_fwd_t   alu_wb_i,
    input  idu_pkg::wb_fwd_t   lsu_wb_i,
    input  idu_pkg::rf_wb_t    rf_wb_i,
    input  logic               alu_rdy_i,
    output logic               alu_vld_o,
    output idu_pkg::alu_req_t  alu_req_o
);

    idu_pkg::alu_op_e  op;
    idu_pkg::imm_fmt_e fmt;
    logic              use_rs1;
    logic              use_rs2;
    logic              src2_imm;
    logic              wb_vld;
    idu_pkg::word_t    imm;
    idu_pkg::word_t    br_st_imm;
    idu_pkg::word_t    src1;
    idu_pkg::word_t    src2;
    logic              ld_stall;
    idu_pkg::alu_req_t req;

    idu_op_decoder dec_inst (
        .instr_i   (ifu_instr_i),
        .op_o      (op),
        .fmt_o     (fmt),
        .use_rs1_o (use_rs1),
        .use_rs2_o (use_rs2),
        .src2_imm_o(src2_imm),
        .wb_vld_o  (wb_vld)
    );

    idu_imm_gen imm_inst (
        .instr_i    (ifu_instr_i),
        .fmt_i      (fmt),
        .imm_o      (imm),
        .br_st_imm_o(br_st_imm)
    );

    idu_operand_bypass byp_inst (
        .instr_i      (ifu_instr_i),
        .use_rs1_i    (use_rs1),
        .use_rs2_i    (use_rs2),
        .src2_imm_i   (src2_imm),
        .imm_i        (imm),
        .rf_rs1_data_i(rf_rs1_data_i),
        .rf_rs2_data_i(rf_rs2_data_i),
        .alu_wb_i     (alu_wb_i),
        .lsu_wb_i     (lsu_wb_i),
        .rf_wb_i      (rf_wb_i),
        .rf_rs1_addr_o(rf_rs1_addr_o),
        .rf_rs2_addr_o(rf_rs2_addr_o),
        .src1_o       (src1),
        .src2_o       (src2),
        .ld_stall_o   (ld_stall)
    );

    // request packet, rd comes from the raw word
    assign req.op        = op;
    assign req.src1      = src1;
    assign req.src2      = src2;
    assign req.br_st_imm = br_st_imm;
    assign req.pc        = ifu_pc_i;
    assign req.wb_addr   = ifu_instr_i[11:7];
    assign req.wb_vld    = wb_vld;

    idu_stage_reg stage_inst (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .ifu_vld_i (ifu_vld_i),
        .flush_i   (flush_i),
        .ld_stall_i(ld_stall),
        .alu_rdy_i (alu_rdy_i),
        .req_i     (req),
        .idu_rdy_o (idu_rdy_o),
        .alu_vld_o (alu_vld_o),
        .alu_req_o (alu_req_o)
    );

endmodule

/* tests/tb_idu_checks.svh */
`ifndef TB_IDU_CHECKS_SVH
`define TB_IDU_CHECKS_SVH

task automatic check_req(input string name, input idu_pkg::alu_req_t exp,
                         input idu_pkg::alu_req_t act);
    if (act !== exp) begin
        mismatch_cnt++;
        $display("Mismatch %s req: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_rdy(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        mismatch_cnt++;
        $display("Mismatch %s: expected %b, actual %b", name, exp, act);
    end
endtask

task automatic check_op(input string name, input idu_pkg::alu_op_e exp,
                        input idu_pkg::alu_op_e act);
    if (act !== exp) begin
        mismatch_cnt++;
        $display("Mismatch %s op: expected %s, actual %s", name, exp.name(), act.name());
    end
endtask

task automatic check_addr(input string name, input idu_pkg::reg_addr_t exp,
                          input idu_pkg::reg_addr_t act);
    if (act !== exp) begin
        mismatch_cnt++;
        $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
    end
endtask

// fibonacci lfsr with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

`endif

/* tests/tb_idu.sv */
module tb_idu;

    typedef struct packed {
        logic [31:0]       id;
        idu_pkg::instr_t   instr;
        idu_pkg::word_t    pc;
        idu_pkg::word_t    d1;
        idu_pkg::word_t    d2;
        idu_pkg::wb_fwd_t  aw;
        idu_pkg::wb_fwd_t  lw;
        idu_pkg::rf_wb_t   rw;
        logic              ar;
        logic              fl;
        idu_pkg::alu_req_t exp;
        logic              erdy;
    } vec_t;

    logic               clk;
    logic               rst_n_i;
    logic               flush_i;
    logic               ifu_vld_i;
    idu_pkg::instr_t    ifu_instr_i;
    idu_pkg::word_t     ifu_pc_i;
    logic               idu_rdy_o;
    idu_pkg::reg_addr_t rf_rs1_addr_o;
    idu_pkg::reg_addr_t rf_rs2_addr_o;
    idu_pkg::word_t     rf_rs1_data_i;
    idu_pkg::word_t     rf_rs2_data_i;
    idu_pkg::wb_fwd_t   alu_wb_i;
    idu_pkg::wb_fwd_t   lsu_wb_i;
    idu_pkg::rf_wb_t    rf_wb_i;
    logic               alu_rdy_i;
    logic               alu_vld_o;
    idu_pkg::alu_req_t  alu_req_o;

    int          mismatch_cnt = 0;
    int          other_cnt = 0;
    logic        load_done = 1'b0;
    logic [31:0] lfsr = 32'he93bd343;
    vec_t        vecs[$];

    `include "tb_idu_checks.svh"

    idu idu_inst (.*);

    always #5 clk = ~clk;

    task automatic read_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] id, instr, pc, d1, d2, es1, es2, eb;
        logic [38:0] aw, lw;
        logic [37:0] rw;
        logic [4:0]  eop, ewa;
        logic        ar, fl, ewv, erdy;
        vec_t        v;
        fd = $fopen("tests/idu_testdata.hex", "r");
        if (fd == 0) begin
            other_cnt++;
            $display("cannot open the stimulus file tests/idu_testdata.hex");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        id, instr, pc, d1, d2, aw, lw, rw, ar, fl,
                        eop, es1, es2, eb, ewa, ewv, erdy);
            // comment lines do not scan
            if (n == 17) begin
                v.id = id;
                v.instr = instr;
                v.pc = pc;
                v.d1 = d1;
                v.d2 = d2;
                v.aw = aw;
                v.lw = lw;
                v.rw = rw;
                v.ar = ar;
                v.fl = fl;
                v.exp.op = idu_pkg::alu_op_e'(eop);
                v.exp.src1 = es1;
                v.exp.src2 = es2;
                v.exp.br_st_imm = eb;
                v.exp.pc = pc;
                v.exp.wb_addr = ewa;
                v.exp.wb_vld = ewv;
                v.erdy = erdy;
                vecs.push_back(v);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_vector(input vec_t v);
        string name;
        int    gap;
        name = $sformatf("vec%0d", v.id);
        @(negedge clk);
        ifu_vld_i = 1'b1;
        ifu_instr_i = v.instr;
        ifu_pc_i = v.pc;
        rf_rs1_data_i = v.d1;
        rf_rs2_data_i = v.d2;
        alu_wb_i = v.aw;
        lsu_wb_i = v.lw;
        rf_wb_i = v.rw;
        flush_i = v.fl;
        alu_rdy_i = 1'b1;
        #1 check_rdy({name, " rdy"}, v.erdy, idu_rdy_o);
        // rs1 and rs2 fields of the instruction word
        check_addr({name, " rs1 addr"}, v.instr[19:15], rf_rs1_addr_o);
        check_addr({name, " rs2 addr"}, v.instr[24:20], rf_rs2_addr_o);
        if (v.fl) begin
            @(negedge clk);
            check_rdy({name, " vld under flush"}, 1'b0, alu_vld_o);
            ifu_vld_i = 1'b0;
            flush_i = 1'b0;
        end else if (!v.erdy) begin
            // nothing may be accepted under a load-use hazard
            repeat (2) @(negedge clk);
            check_rdy({name, " vld during stall"}, 1'b0, alu_vld_o);
            alu_wb_i = '0;
            lsu_wb_i = '0;
            ifu_vld_i = 1'b0;
            #1 check_rdy({name, " rdy after clear"}, 1'b1, idu_rdy_o);
        end else begin
            @(negedge clk);
            check_rdy({name, " vld"}, 1'b1, alu_vld_o);
            check_op(name, v.exp.op, alu_req_o.op);
            check_req(name, v.exp, alu_req_o);
            alu_rdy_i = v.ar;
            if (!v.ar) begin
                repeat (3) begin
                    #1 check_rdy({name, " rdy held"}, 1'b0, idu_rdy_o);
                    @(negedge clk);
                    check_rdy({name, " vld held"}, 1'b1, alu_vld_o);
                    check_req({name, " held"}, v.exp, alu_req_o);
                end
                alu_rdy_i = 1'b1;
            end
            ifu_vld_i = 1'b0;
        end
        gap = 0;
        repeat (3) begin
            lfsr = lfsr_next(lfsr);
            gap = gap * 2 + int'(lfsr[0]);
        end
        repeat (gap) @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        ifu_vld_i = 1'b0;
        ifu_instr_i = '0;
        ifu_pc_i = '0;
        rf_rs1_data_i = '0;
        rf_rs2_data_i = '0;
        alu_wb_i = '0;
        lsu_wb_i = '0;
        rf_wb_i = '0;
        alu_rdy_i = 1'b1;
        read_vectors();
        load_done = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        #1 check_rdy("reset vld", 1'b0, alu_vld_o);
        check_rdy("reset rdy", 1'b1, idu_rdy_o);
        foreach (vecs[i]) begin
            run_vector(vecs[i]);
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0 && vecs.size() > 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // run length scales with the vector count
    initial begin
        wait (load_done);
        #((vecs.size() * 20 + 100) * 10);
        other_cnt++;
        $display("timeout: the run did not finish in time");
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* tests/idu_testdata.hex */
# id instr pc rs1_data rs2_data alu_wb lsu_wb rf_wb alu_rdy flush
# exp_op exp_src1 exp_src2 exp_br_st_imm exp_wb_addr exp_wb_vld exp_rdy
01 002081B3 00000000 11111111 22222222 0 0 0 1 0 01 11111111 22222222 00000000 03 1 1
02 402081B3 00000004 11111111 22222222 0 0 0 1 0 02 11111111 22222222 00000000 03 1 1
03 4020D2B3 00000008 11111111 22222222 0 0 0 1 0 0a 11111111 22222222 00000000 05 1 1
04 FFF08213 0000000C 11111111 22222222 0 0 0 1 0 01 11111111 FFFFFFFF 00000000 04 1 1
05 FFF08213 00000010 11111111 22222222 5FDEADBEEF 0 0 1 0 01 11111111 FFFFFFFF 00000000 04 1 1
06 00812303 00000014 11111111 22222222 0 0 0 1 0 13 11111111 00000008 00000000 06 1 1
07 FE20AE23 00000018 11111111 22222222 0 0 0 1 0 18 11111111 22222222 FFFFFFFC 1c 0 1
08 FE208CE3 0000001C 11111111 22222222 0 0 0 1 0 0b 11111111 22222222 FFFFFFF8 19 0 1
09 123453B7 00000020 11111111 22222222 0 0 0 1 0 19 11111111 12345000 00000000 07 1 1
0a FFFFF417 00000100 11111111 22222222 0 0 0 1 0 1a 11111111 FFFFF000 00000000 08 1 1
0b FF1FF0EF 00000104 11111111 22222222 0 0 0 1 0 1b 11111111 FFFFFFF0 00000000 01 1 1
0c 00428067 00000108 11111111 22222222 0 0 0 1 0 1c 11111111 00000004 00000000 00 1 1
0d 0000007F 0000010C 11111111 22222222 0 0 0 1 0 00 11111111 22222222 00000000 00 0 1
0e 002081B3 00000110 11111111 22222222 41AAAA0001 41BBBB0001 22CCCC0002 1 0 01 AAAA0001 CCCC0002 00000000 03 1 1
0f 002081B3 00000114 11111111 22222222 0 41BBBB0001 21CCCC0001 1 0 01 BBBB0001 22222222 00000000 03 1 1
10 002001B3 00000118 11111111 22222222 40AAAA0000 0 0 1 0 01 11111111 22222222 00000000 03 1 1
11 002081B3 0000011C 11111111 22222222 0 6200000000 0 1 0 00 00000000 00000000 00000000 00 0 0
12 002081B3 00000120 11111111 22222222 6100000000 0 0 1 0 00 00000000 00000000 00000000 00 0 0
13 002081B3 00000124 11111111 22222222 0 0 0 0 0 01 11111111 22222222 00000000 03 1 1
14 002081B3 00000128 11111111 22222222 0 0 0 1 1 00 00000000 00000000 00000000 00 0 1

/* files.f */
+incdir+tests
rtl/idu_pkg.sv
rtl/idu_op_decoder.sv
rtl/idu_imm_gen.sv
rtl/idu_operand_bypass.sv
rtl/idu_stage_reg.sv
rtl/idu.sv
tests/tb_idu.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_idu -o sim_tb_idu
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/sim_tb_idu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with an error"
    exit 1
fi

if echo "$out" | grep -q "TEST PASSED"; then
    exit 0
fi
exit 1
